//--- list.f
verilog/arch_defs_pkg.sv
verilog/control_unit.sv
verilog/program_counter.sv
verilog/register_memory_address.sv
verilog/register_bank.sv
verilog/alu.sv
verilog/cpu.sv
verif/cpu_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the CPU testbench, status follows the pass line
cd "$(dirname "$0")" &&
verilator --binary -f list.f --top-module cpu_tb -o cpu_tb_sim &&
./obj_dir/cpu_tb_sim | tee /dev/stderr | grep -q "Result: PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- verif/cpu_tb.sv
`default_nettype none

module cpu_tb;
    import arch_defs_pkg::*;

    localparam int    CLK_PERIOD   = 20;
    // Programs start away from address zero
    localparam addr_t RESET_VECTOR = 16'h0300;

    logic       clk;
    logic       rst_n;
    addr_t      mem_address;
    logic       mem_read;
    logic       mem_write;
    data_t      mem_data_in;
    data_t      mem_data_out;
    logic       halt;
    logic       flag_zero;
    logic       flag_carry;
    logic       flag_negative;
    data_t      debug_a;
    addr_t      debug_pc;

    // Memory image seen by the DUT and the copy the model runs on
    logic [7:0] mem [65536];
    logic [7:0] model_mem [65536];
    addr_t      wptr;
    addr_t      exp_addr [$];
    data_t      exp_data [$];
    int         errors;
    int         checks;
    int         tests;
    longint     deadline;

    cpu #(.RESET_VECTOR(RESET_VECTOR)) i_dut (
        .clk(clk), .rst_n(rst_n),
        .mem_address(mem_address), .mem_read(mem_read), .mem_write(mem_write),
        .mem_data_in(mem_data_in), .mem_data_out(mem_data_out),
        .halt(halt), .flag_zero(flag_zero), .flag_carry(flag_carry),
        .flag_negative(flag_negative), .debug_a(debug_a), .debug_pc(debug_pc)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ====================================================================
    // Memory model
    // ====================================================================
    // Asynchronous read and a write on the rising edge
    assign mem_data_in = mem[mem_address];

    always @(posedge clk) begin
        if (mem_write)
            mem[mem_address] <= mem_data_out;
    end

    // ====================================================================
    // Reference model
    // ====================================================================
    // Runs the program by the instruction rules and returns the cycle count
    function automatic int run_model(output data_t fa, output logic [2:0] ff,
                                     output addr_t haddr);
        addr_t      pc;
        addr_t      target;
        logic [7:0] op;
        logic [7:0] a;
        logic [7:0] b;
        logic [8:0] r;
        logic       z;
        logic       c;
        logic       n;
        int         cyc;
        pc = RESET_VECTOR;
        a = '0;
        b = '0;
        z = 1'b0;
        c = 1'b0;
        n = 1'b0;
        haddr = '0;
        // One edge to leave the idle state
        cyc = 1;
        for (int step = 0; step < 4096; step++) begin
            op = model_mem[pc];
            pc = pc + 16'd1;
            target = {model_mem[pc + 16'd1], model_mem[pc]};
            if (op == OP_HLT) begin
                haddr = pc - 16'd1;
                cyc = cyc + 3;
                break;
            end else if (op == OP_LDI_A || op == OP_LDI_B) begin
                if (op == OP_LDI_A)
                    a = model_mem[pc];
                else
                    b = model_mem[pc];
                z = (model_mem[pc] == 8'h00);
                n = model_mem[pc][7];
                c = 1'b0;
                pc = pc + 16'd1;
                cyc = cyc + 4;
            end else if (op == OP_LDA || op == OP_STA) begin
                pc = pc + 16'd2;
                cyc = cyc + 9;
                if (op == OP_LDA) begin
                    a = model_mem[target];
                    z = (a == 8'h00);
                    n = a[7];
                    c = 1'b0;
                end else begin
                    model_mem[target] = a;
                    exp_addr.push_back(target);
                    exp_data.push_back(a);
                end
            end else if (op >= OP_ADD && op <= OP_DCR) begin
                case (op)
                    OP_ADD: r = {1'b0, a} + {1'b0, b};
                    OP_SUB: r = {a < b, a - b};
                    OP_AND: r = {1'b0, a & b};
                    OP_OR:  r = {1'b0, a | b};
                    OP_XOR: r = {1'b0, a ^ b};
                    // Carry survives increment and decrement
                    OP_INR: r = {c, a + 8'd1};
                    default: r = {c, a - 8'd1};
                endcase
                a = r[7:0];
                c = r[8];
                z = (a == 8'h00);
                n = a[7];
                cyc = cyc + 4;
            end else if (op == OP_JMP || (op == OP_JZ && z) || (op == OP_JC && c)) begin
                pc = target;
                cyc = cyc + 8;
            end else if (op == OP_JZ || op == OP_JC) begin
                pc = pc + 16'd2;
                cyc = cyc + 6;
            end else begin
                // NOP and undefined opcodes
                cyc = cyc + 2;
            end
        end
        fa = a;
        ff = {n, c, z};
        return cyc;
    endfunction

    // ====================================================================
    // Compare process
    // ====================================================================
    // Write strobes are steady around the falling edge
    always @(negedge clk) begin
        if (rst_n && mem_write) begin
            assert (exp_addr.size() > 0) else begin
                $display("unexpected extra write to address %04h at time %0t",
                         mem_address, $time);
                errors++;
            end
            if (exp_addr.size() > 0) begin
                check_value("mem_address", int'(exp_addr.pop_front()), int'(mem_address));
                check_value("mem_data_out", int'(exp_data.pop_front()), int'(mem_data_out));
            end
        end
    end

    // Run ends once the time allowed for the current test runs out
    always @(posedge clk) begin
        if ($time > deadline) begin
            $display("timeout, the CPU did not halt in the time given to the test");
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input int expected, input int actual);
        checks++;
        assert (expected == actual) else begin
            $display("error t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // Background fill differs at every address
    task automatic clear_memory();
        for (int i = 0; i < 65536; i++) begin
            mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5a;
        end
        wptr = RESET_VECTOR;
    endtask

    task automatic emit(input logic [7:0] value);
        mem[wptr] = value;
        wptr = wptr + 16'd1;
    endtask

    task automatic emit_addr(input logic [7:0] op, input addr_t target);
        emit(op);
        emit(target[7:0]);
        emit(target[15:8]);
    endtask

    // Reset held for 4 cycles with the state checked just before release
    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_value("debug_pc", int'(RESET_VECTOR), int'(debug_pc));
        check_value("halt", 0, int'(halt));
        check_value("flags", 0, int'({flag_negative, flag_carry, flag_zero}));
        check_value("mem_read", 0, int'(mem_read));
        check_value("mem_write", 0, int'(mem_write));
        @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic run_test(input string name);
        int         cyc;
        int         err0;
        data_t      fa;
        logic [2:0] ff;
        addr_t      haddr;
        err0 = errors;
        exp_addr.delete();
        exp_data.delete();
        model_mem = mem;
        cyc = run_model(fa, ff, haddr);
        deadline = $time + longint'((cyc + 60) * CLK_PERIOD);
        apply_reset();
        do @(negedge clk); while (halt !== 1'b1);
        check_value("debug_a", int'(fa), int'(debug_a));
        check_value("flags", int'(ff), int'({flag_negative, flag_carry, flag_zero}));
        // PC parks one past the HLT opcode
        repeat (20) begin
            @(negedge clk);
            check_value("halt", 1, int'(halt));
            check_value("debug_pc", int'(haddr + 16'd1), int'(debug_pc));
        end
        assert (exp_addr.size() == 0) else begin
            $display("%0d expected writes never happened", exp_addr.size());
            errors++;
        end
        tests++;
        $display("test %s: %0d errors", name, errors - err0);
    endtask

    // ====================================================================
    // Tests
    // ====================================================================
    initial begin
        int         seed;
        logic [7:0] va;
        logic [7:0] vb;
        addr_t      src;
        seed = 32'hfe010949;
        void'($urandom(seed));
        clk = 1'b0;
        rst_n = 1'b0;
        errors = 0;
        checks = 0;
        tests = 0;
        deadline = 100000;

        clear_memory();
        emit(OP_HLT);
        run_test("reset");

        // Zero, negative and random immediates
        for (int k = 0; k < 4; k++) begin
            va = (k == 0) ? 8'h00 : (k == 1) ? (8'($urandom) | 8'h80) : 8'($urandom);
            clear_memory();
            emit(OP_LDI_A);
            emit(va);
            emit_addr(OP_STA, 16'h8000 + 16'(k));
            emit(OP_HLT);
            run_test("ldi_sta");
        end

        // SUB first leaves a random borrow for the op under test
        for (int k = 0; k < 7; k++) begin
            va = 8'($urandom);
            vb = 8'($urandom);
            clear_memory();
            emit(OP_LDI_A);
            emit(va);
            emit(OP_LDI_B);
            emit(vb);
            emit(OP_SUB);
            emit(OP_ADD + 8'(k));
            emit_addr(OP_STA, 16'h8100);
            emit(OP_HLT);
            run_test("alu");
        end

        for (int k = 0; k < 2; k++) begin
            src = 16'h4000 | 16'($urandom & 32'h0fff);
            clear_memory();
            mem[src] = (k == 0) ? 8'h00 : 8'($urandom);
            emit_addr(OP_LDA, src);
            emit_addr(OP_STA, 16'h8200);
            emit(OP_HLT);
            run_test("lda_sta");
        end

        // Each skipped store would show up as an extra write
        clear_memory();
        emit(OP_LDI_A);
        emit(8'h00);
        emit_addr(OP_JZ, 16'h0040);
        emit_addr(OP_STA, 16'h9000);
        wptr = 16'h0040;
        emit(OP_LDI_A);
        emit(8'hff);
        emit(OP_LDI_B);
        emit(8'h01);
        emit(OP_ADD);
        emit_addr(OP_JC, 16'h0080);
        emit_addr(OP_STA, 16'h9001);
        wptr = 16'h0080;
        emit(OP_LDI_A);
        emit(8'h05);
        emit_addr(OP_JZ, 16'h00c0);
        emit_addr(OP_STA, 16'h9002);
        emit_addr(OP_JC, 16'h00c0);
        emit_addr(OP_STA, 16'h9003);
        emit_addr(OP_JMP, 16'h0100);
        emit_addr(OP_STA, 16'h9004);
        wptr = 16'h0100;
        emit_addr(OP_STA, 16'h9005);
        emit(OP_HLT);
        run_test("jumps");

        // Undefined opcode runs as NOP before the halt
        clear_memory();
        emit(OP_NOP);
        emit(8'h77);
        emit(OP_LDI_A);
        emit(8'h3c);
        emit(OP_HLT);
        emit_addr(OP_STA, 16'h9100);
        run_test("hlt");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/cpu.sv
`default_nettype none

module cpu #(
    parameter arch_defs_pkg::addr_t RESET_VECTOR = 16'h0000
) (
    input  wire                        clk,
    input  wire                        rst_n,
    // Memory port
    output arch_defs_pkg::addr_t       mem_address,
    output logic                       mem_read,
    output logic                       mem_write,
    input  wire arch_defs_pkg::data_t  mem_data_in,
    output arch_defs_pkg::data_t       mem_data_out,
    // Status
    output logic                       halt,
    output logic                       flag_zero,
    output logic                       flag_carry,
    output logic                       flag_negative,
    // Debug taps
    output arch_defs_pkg::data_t       debug_a,
    output arch_defs_pkg::addr_t       debug_pc
);
    import arch_defs_pkg::*;

    data_t                 internal_bus;
    data_t                 a, b, t1, t2, alu_result;
    opcode_t               ir;
    addr_t                 pc_count;
    logic [FLAG_COUNT-1:0] flags;
    alu_op_t               alu_op;
    logic load_a, load_b, load_t1, load_t2, load_ir;
    logic load_mar_pc, load_mar_low, load_mar_high;
    logic load_pc_low, load_pc_high, pc_enable;
    logic alu_latch, load_flags, load_sets_zn;
    logic oe_ram, oe_alu, oe_a, oe_t1, oe_t2;

    // ====================================================================
    // Shared bus with one driver at a time by priority
    // ====================================================================
    assign internal_bus = oe_ram ? mem_data_in :
                          oe_alu ? alu_result  :
                          oe_a   ? a           :
                          oe_t1  ? t1          :
                          oe_t2  ? t2          : '0;

    // Memory side
    assign mem_read     = oe_ram;
    // A reaches the bus only for a store
    assign mem_write    = oe_a;
    assign mem_data_out = internal_bus;

    assign flag_zero     = flags[FLAG_Z];
    assign flag_carry    = flags[FLAG_C];
    assign flag_negative = flags[FLAG_N];
    assign debug_a       = a;
    assign debug_pc      = pc_count;

    // ====================================================================
    // Sequencer and datapath
    // ====================================================================
    control_unit u_control_unit (
        .clk(clk), .rst_n(rst_n), .opcode(ir), .flags(flags),
        .alu_op(alu_op), .halt(halt),
        .load_a(load_a), .load_b(load_b), .load_t1(load_t1),
        .load_t2(load_t2), .load_ir(load_ir),
        .load_mar_pc(load_mar_pc), .load_mar_low(load_mar_low),
        .load_mar_high(load_mar_high),
        .load_pc_low(load_pc_low), .load_pc_high(load_pc_high), .pc_enable(pc_enable),
        .alu_latch(alu_latch), .load_flags(load_flags), .load_sets_zn(load_sets_zn),
        .oe_ram(oe_ram), .oe_alu(oe_alu), .oe_a(oe_a), .oe_t1(oe_t1), .oe_t2(oe_t2)
    );

    program_counter #(.RESET_VECTOR(RESET_VECTOR)) u_program_counter (
        .clk(clk), .rst_n(rst_n), .enable(pc_enable),
        .load_low(load_pc_low), .load_high(load_pc_high),
        .bus_in(internal_bus), .count(pc_count)
    );

    register_memory_address u_register_memory_address (
        .clk(clk), .rst_n(rst_n), .load_pc(load_mar_pc),
        .load_low(load_mar_low), .load_high(load_mar_high),
        .bus_in(internal_bus), .pc_in(pc_count), .address(mem_address)
    );

    register_bank u_register_bank (
        .clk(clk), .rst_n(rst_n),
        .load_a(load_a), .load_b(load_b), .load_t1(load_t1),
        .load_t2(load_t2), .load_ir(load_ir), .bus_in(internal_bus),
        .a(a), .b(b), .t1(t1), .t2(t2), .ir(ir)
    );

    // ALU always works on A and B
    alu u_alu (
        .clk(clk), .rst_n(rst_n), .in_one(a), .in_two(b),
        .bus_in(internal_bus), .alu_op(alu_op), .latch(alu_latch),
        .load_flags(load_flags), .load_sets_zn(load_sets_zn),
        .result(alu_result), .flags(flags)
    );

endmodule

`default_nettype wire

//--- verilog/alu.sv
`default_nettype none

module alu (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire arch_defs_pkg::data_t            in_one,
    input  wire arch_defs_pkg::data_t            in_two,
    input  wire arch_defs_pkg::data_t            bus_in,
    input  wire arch_defs_pkg::alu_op_t          alu_op,
    input  wire                                  latch,
    input  wire                                  load_flags,
    input  wire                                  load_sets_zn,
    output arch_defs_pkg::data_t                 result,
    output logic [arch_defs_pkg::FLAG_COUNT-1:0] flags
);
    import arch_defs_pkg::*;

    // Carry out in the top bit
    logic [DATA_WIDTH:0]   wide;
    logic [FLAG_COUNT-1:0] flags_d;

    always_comb begin
        unique case (alu_op)
            ALU_ADD: wide = {1'b0, in_one} + {1'b0, in_two};
            // Top bit is the borrow when in_one < in_two
            ALU_SUB: wide = {1'b0, in_one} - {1'b0, in_two};
            ALU_AND: wide = {1'b0, in_one & in_two};
            ALU_OR:  wide = {1'b0, in_one | in_two};
            ALU_XOR: wide = {1'b0, in_one ^ in_two};
            // Increment and decrement pass the old carry through
            ALU_INR: wide = {flags[FLAG_C], in_one + DATA_WIDTH'(1)};
            ALU_DCR: wide = {flags[FLAG_C], in_one - DATA_WIDTH'(1)};
            default: wide = '0;
        endcase
    end

    // Loads take Z and N from the bus and clear C
    always_comb begin
        flags_d = '0;
        if (load_sets_zn) begin
            flags_d[FLAG_Z] = (bus_in == '0);
            flags_d[FLAG_N] = bus_in[DATA_WIDTH-1];
        end else begin
            flags_d[FLAG_Z] = (wide[DATA_WIDTH-1:0] == '0);
            flags_d[FLAG_C] = wide[DATA_WIDTH];
            flags_d[FLAG_N] = wide[DATA_WIDTH-1];
        end
    end

    // Result holds until it is moved onto the bus
    always_ff @(posedge clk) begin
        if (latch)
            result <= wide[DATA_WIDTH-1:0];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            flags <= '0;
        else if (load_flags)
            flags <= flags_d;
    end

endmodule

`default_nettype wire

//--- verilog/register_bank.sv
`default_nettype none

module register_bank (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        load_a,
    input  wire                        load_b,
    input  wire                        load_t1,
    input  wire                        load_t2,
    input  wire                        load_ir,
    input  wire arch_defs_pkg::data_t  bus_in,
    output arch_defs_pkg::data_t       a,
    output arch_defs_pkg::data_t       b,
    output arch_defs_pkg::data_t       t1,
    output arch_defs_pkg::data_t       t2,
    output arch_defs_pkg::opcode_t     ir
);

    // All five registers listen to the shared bus
    // Only one load is active in any microstep
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a  <= '0;
            b  <= '0;
            t1 <= '0;
            t2 <= '0;
            // Cleared IR decodes as NOP
            ir <= '0;
        end else begin
            // Accumulator and second ALU operand
            if (load_a)
                a <= bus_in;
            if (load_b)
                b <= bus_in;
            // Operand bytes of address instructions
            if (load_t1)
                t1 <= bus_in;
            if (load_t2)
                t2 <= bus_in;
            if (load_ir)
                ir <= bus_in;
        end
    end

endmodule

`default_nettype wire

//--- verilog/register_memory_address.sv
`default_nettype none

module register_memory_address (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        load_pc,
    input  wire                        load_low,
    input  wire                        load_high,
    input  wire arch_defs_pkg::data_t  bus_in,
    input  wire arch_defs_pkg::addr_t  pc_in,
    output arch_defs_pkg::addr_t       address
);
    import arch_defs_pkg::*;

    // Drives the memory address directly
    // Fetch copies the full PC, LDA and STA build it byte by byte
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            address <= '0;
        end else if (load_pc) begin
            address <= pc_in;
        end else if (load_low) begin
            address[DATA_WIDTH-1:0] <= bus_in;
        end else if (load_high) begin
            // High byte comes from temp 2
            address[ADDR_WIDTH-1:DATA_WIDTH] <= bus_in;
        end
    end

endmodule

`default_nettype wire

//--- verilog/program_counter.sv
`default_nettype none

module program_counter #(
    parameter arch_defs_pkg::addr_t RESET_VECTOR = 16'h0000
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        enable,
    input  wire                        load_low,
    input  wire                        load_high,
    input  wire arch_defs_pkg::data_t  bus_in,
    output arch_defs_pkg::addr_t       count
);
    import arch_defs_pkg::*;

    // Byte loads win over counting
    // Jump targets arrive low byte first, one per cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Program origin
            count <= RESET_VECTOR;
        end else if (load_low) begin
            count[DATA_WIDTH-1:0] <= bus_in;
        end else if (load_high) begin
            count[ADDR_WIDTH-1:DATA_WIDTH] <= bus_in;
        end else if (enable) begin
            count <= count + ADDR_WIDTH'(1);
        end
    end

endmodule

`default_nettype wire

//--- verilog/control_unit.sv
`default_nettype none

module control_unit (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire arch_defs_pkg::opcode_t          opcode,
    input  wire [arch_defs_pkg::FLAG_COUNT-1:0]  flags,
    output arch_defs_pkg::alu_op_t               alu_op,
    output logic                                 halt,
    // Register loads
    output logic load_a, load_b, load_t1, load_t2, load_ir,
    output logic load_mar_pc, load_mar_low, load_mar_high,
    output logic load_pc_low, load_pc_high, pc_enable,
    output logic alu_latch, load_flags, load_sets_zn,
    // Bus drivers
    output logic oe_ram, oe_alu, oe_a, oe_t1, oe_t2
);
    import arch_defs_pkg::*;

    typedef enum logic [3:0] {
        IDLE, FETCH_0, FETCH_1,
        EXEC_0, EXEC_1, EXEC_2, EXEC_3, EXEC_4, EXEC_5, EXEC_6,
        HALTED
    } state_t;

    // Bit positions in the strobe word
    localparam int S_LOAD_A = 0, S_LOAD_B = 1, S_LOAD_T1 = 2, S_LOAD_T2 = 3,
                   S_LOAD_IR = 4, S_MAR_PC = 5, S_MAR_LOW = 6, S_MAR_HIGH = 7,
                   S_PC_LOW = 8, S_PC_HIGH = 9, S_PC_EN = 10, S_ALU_LATCH = 11,
                   S_LOAD_FLAGS = 12, S_SETS_ZN = 13, S_OE_RAM = 14, S_OE_ALU = 15,
                   S_OE_A = 16, S_OE_T1 = 17, S_OE_T2 = 18, S_HALT = 19, S_COUNT = 20;

    state_t             state_q, state_d;
    logic [S_COUNT-1:0] strobe_q, strobe_d;
    logic               is_ldi, is_alu, is_jump, is_addr, jump_skip;

    // ====================================================================
    // Opcode classes
    // ====================================================================
    assign is_ldi  = (opcode == OP_LDI_A) || (opcode == OP_LDI_B);
    assign is_alu  = opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_INR, OP_DCR};
    assign is_jump = opcode inside {OP_JMP, OP_JZ, OP_JC};
    assign is_addr = is_jump || (opcode == OP_LDA) || (opcode == OP_STA);
    // Conditional jump whose flag is clear
    assign jump_skip = ((opcode == OP_JZ) && !flags[FLAG_Z]) ||
                       ((opcode == OP_JC) && !flags[FLAG_C]);

    always_comb begin
        unique case (opcode)
            OP_SUB:  alu_op = ALU_SUB;
            OP_AND:  alu_op = ALU_AND;
            OP_OR:   alu_op = ALU_OR;
            OP_XOR:  alu_op = ALU_XOR;
            OP_INR:  alu_op = ALU_INR;
            OP_DCR:  alu_op = ALU_DCR;
            default: alu_op = ALU_ADD;
        endcase
    end

    // ====================================================================
    // Microstep sequencing
    // ====================================================================
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE:    state_d = FETCH_0;
            FETCH_0: state_d = FETCH_1;
            FETCH_1: state_d = EXEC_0;
            // EXEC_0 already did PC to MAR, so NOP goes straight to the read
            EXEC_0: begin
                if (opcode == OP_HLT)
                    state_d = HALTED;
                else if (is_ldi || is_alu || is_addr)
                    state_d = EXEC_1;
                else
                    state_d = FETCH_1;
            end
            EXEC_1:  state_d = is_addr ? EXEC_2 : FETCH_0;
            EXEC_2:  state_d = EXEC_3;
            EXEC_3:  state_d = jump_skip ? FETCH_0 : EXEC_4;
            EXEC_4:  state_d = EXEC_5;
            EXEC_5:  state_d = is_jump ? FETCH_0 : EXEC_6;
            EXEC_6:  state_d = FETCH_0;
            HALTED:  state_d = HALTED;
            default: state_d = FETCH_0;
        endcase
    end

    // Strobes for the step being entered
    always_comb begin
        strobe_d = '0;
        unique case (state_d)
            FETCH_0, EXEC_2: strobe_d[S_MAR_PC] = 1'b1;
            FETCH_1, EXEC_3: begin
                strobe_d[S_OE_RAM]  = 1'b1;
                strobe_d[S_PC_EN]   = 1'b1;
                strobe_d[S_LOAD_IR] = (state_d == FETCH_1);
                strobe_d[S_LOAD_T2] = (state_d == EXEC_3);
            end
            // IR is still loading here, so this step is the same for all opcodes
            EXEC_0: begin
                strobe_d[S_MAR_PC]    = 1'b1;
                strobe_d[S_ALU_LATCH] = 1'b1;
            end
            EXEC_1: begin
                if (is_alu) begin
                    strobe_d[S_OE_ALU]     = 1'b1;
                    strobe_d[S_LOAD_A]     = 1'b1;
                    strobe_d[S_LOAD_FLAGS] = 1'b1;
                end else begin
                    strobe_d[S_OE_RAM]     = 1'b1;
                    strobe_d[S_PC_EN]      = 1'b1;
                    strobe_d[S_LOAD_A]     = (opcode == OP_LDI_A);
                    strobe_d[S_LOAD_B]     = (opcode == OP_LDI_B);
                    strobe_d[S_LOAD_T1]    = is_addr;
                    strobe_d[S_LOAD_FLAGS] = is_ldi;
                    strobe_d[S_SETS_ZN]    = is_ldi;
                end
            end
            // Operand bytes go to PC for jumps, to MAR otherwise
            EXEC_4: begin
                strobe_d[S_OE_T1]   = 1'b1;
                strobe_d[S_PC_LOW]  = is_jump;
                strobe_d[S_MAR_LOW] = !is_jump;
            end
            EXEC_5: begin
                strobe_d[S_OE_T2]    = 1'b1;
                strobe_d[S_PC_HIGH]  = is_jump;
                strobe_d[S_MAR_HIGH] = !is_jump;
            end
            EXEC_6: begin
                strobe_d[S_OE_RAM]     = (opcode == OP_LDA);
                strobe_d[S_LOAD_A]     = (opcode == OP_LDA);
                strobe_d[S_LOAD_FLAGS] = (opcode == OP_LDA);
                strobe_d[S_SETS_ZN]    = (opcode == OP_LDA);
                strobe_d[S_OE_A]       = (opcode == OP_STA);
            end
            HALTED:  strobe_d[S_HALT] = 1'b1;
            default: strobe_d = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= IDLE;
            strobe_q <= '0;
        end else begin
            state_q  <= state_d;
            strobe_q <= strobe_d;
        end
    end

    // MSB first, matching the bit positions above
    assign {halt, oe_t2, oe_t1, oe_a, oe_alu, oe_ram,
            load_sets_zn, load_flags, alu_latch, pc_enable,
            load_pc_high, load_pc_low, load_mar_high, load_mar_low, load_mar_pc,
            load_ir, load_t2, load_t1, load_b, load_a} = strobe_q;

endmodule

`default_nettype wire

//--- verilog/arch_defs_pkg.sv
`default_nettype none

package arch_defs_pkg;

    // ====================================================================
    // Datapath widths
    // ====================================================================
    localparam int DATA_WIDTH = 8;
    localparam int ADDR_WIDTH = 16;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // ====================================================================
    // Instruction set
    // ====================================================================
    // One byte per opcode, operands follow low byte first
    typedef logic [7:0] opcode_t;

    localparam opcode_t OP_NOP   = 8'h00;
    localparam opcode_t OP_LDI_A = 8'h01;
    localparam opcode_t OP_LDI_B = 8'h02;
    localparam opcode_t OP_LDA   = 8'h03;
    localparam opcode_t OP_STA   = 8'h04;
    // ALU group, always A op B into A
    localparam opcode_t OP_ADD   = 8'h10;
    localparam opcode_t OP_SUB   = 8'h11;
    localparam opcode_t OP_AND   = 8'h12;
    localparam opcode_t OP_OR    = 8'h13;
    localparam opcode_t OP_XOR   = 8'h14;
    localparam opcode_t OP_INR   = 8'h15;
    localparam opcode_t OP_DCR   = 8'h16;
    // Jumps with a 2-byte target
    localparam opcode_t OP_JMP   = 8'h20;
    localparam opcode_t OP_JZ    = 8'h21;
    localparam opcode_t OP_JC    = 8'h22;
    localparam opcode_t OP_HLT   = 8'hFF;

    // ALU operation select
    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_INR, ALU_DCR
    } alu_op_t;

    // Flag register layout
    localparam int FLAG_COUNT = 3;
    localparam int FLAG_Z     = 0;
    localparam int FLAG_C     = 1;
    localparam int FLAG_N     = 2;

endpackage

`default_nettype wire
